// File: hw/memcmd_pkg.sv
// Shared types for the memory-command subsystem
// Address and data widths, the command and response words, and the
// bridge state encoding used by the RTL and the testbench
// Import with a wildcard in the module header where needed

package memcmd_pkg;

	// ********************************************************************
	// Widths that carry a meaning
	// ********************************************************************

	// Request and command address
	typedef logic [15:0] addr_t;

	// Read and write data word
	typedef logic [31:0] data_t;

	// ********************************************************************
	// Handshake payloads
	// ********************************************************************

	// Command word from bridge to target, 49 bits
	typedef struct packed {
		addr_t addr;
		logic  write;
		data_t wdata;
	} cmd_t;

	// Response word from target to bridge
	// Zero for a write
	typedef struct packed {
		data_t rdata;
	} rsp_t;

	// Bridge FSM states
	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_cmd  = 2'd1,
		st_rsp  = 2'd2
	} bridge_state_t;

	// Defaults for the top level parameters
	localparam int DEF_FIFO_DEPTH = 4;
	localparam int DEF_MEM_WORDS  = 256;

endpackage

// File: hw/req_cmd_bridge.sv
// Request to command bridge
// Takes a level-signalled host request, presents it as a command on a
// valid/ready path, then waits for the matching response
// One request in flight at a time, req_done pulses on the response

module req_cmd_bridge
	import memcmd_pkg::*;
(
	input  logic  rvx_port_26,
	input  logic  rvx_port_24,

	// Host request side
	input  logic  req_valid,
	input  logic  req_sel,
	input  logic  req_write,
	input  addr_t req_addr,
	input  data_t req_wdata,
	output logic  req_done,
	output data_t req_rdata,

	// Command path
	output logic  cmd_valid,
	input  logic  cmd_ready,
	output cmd_t  cmd,

	// Response path
	input  logic  rsp_valid,
	output logic  rsp_ready,
	input  rsp_t  rsp
);

	// ********************************************************************
	// Handshake terms
	// ********************************************************************

	bridge_state_t state;

	// Request taken only from idle with both levels high
	logic req_take;
	// Command accepted by the FIFO
	logic cmd_hs;
	// Response accepted by the bridge
	logic rsp_hs;

	assign req_take = (state == st_idle) & req_valid & req_sel;
	assign cmd_hs   = cmd_valid & cmd_ready;
	assign rsp_hs   = rsp_valid & rsp_ready;

	// ********************************************************************
	// FSM
	// ********************************************************************

	always_ff @(posedge rvx_port_26 or negedge rvx_port_24)
	begin
		if (!rvx_port_24)
		begin
			state <= st_idle;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (req_take)
						state <= st_cmd;
				end
				st_cmd:
				begin
					// Response may land in the same cycle as the transfer
					if (cmd_hs)
					begin
						if (rsp_hs)
							state <= st_idle;
						else
							state <= st_rsp;
					end
				end
				st_rsp:
				begin
					if (rsp_hs)
						state <= st_idle;
				end
				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

	// ********************************************************************
	// Outputs
	// ********************************************************************

	// Command offered only while in the cmd state
	assign cmd_valid = (state == st_cmd);

	// Ready for a response once the command is on its way
	assign rsp_ready = (state == st_cmd) | (state == st_rsp);

	// Host holds its request, so the fields stay stable until req_done
	always_comb
	begin
		cmd.addr  = req_addr;
		cmd.write = req_write;
		cmd.wdata = req_wdata;
	end

	// Done strobe is the response handshake itself
	assign req_done  = rsp_hs;
	assign req_rdata = rsp.rdata;

endmodule

// File: hw/cmd_fifo.sv
// Synchronous command FIFO
// Circular buffer of command words with read and write pointers and an
// occupancy count; push and pop may happen in the same cycle
// A push when full or a pop when empty has no effect

module cmd_fifo
	import memcmd_pkg::*;
#(
	parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
)
(
	input  logic rvx_port_26,
	input  logic rvx_port_24,
	input  logic push,
	input  cmd_t push_data,
	input  logic pop,
	output logic full,
	output logic valid,
	output cmd_t head
);

	// Pointer needs at least one bit even for a single entry
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] cnt_t;

	cmd_t store [FIFO_DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;

	logic do_push;
	logic do_pop;

	// Qualified operations
	assign do_push = push & ~full;
	assign do_pop  = pop & valid;

	// Flags straight from the count
	assign full  = (count == cnt_t'(FIFO_DEPTH));
	assign valid = (count != '0);
	assign head  = store[rd_ptr];

	// Pointers and count
	always_ff @(posedge rvx_port_26 or negedge rvx_port_24)
	begin
		if (!rvx_port_24)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop leaves the count alone
			if (do_push & ~do_pop)
				count <= count + 1'b1;
			else if (do_pop & ~do_push)
				count <= count - 1'b1;
		end
	end

	// Entry storage
	always_ff @(posedge rvx_port_26)
	begin
		if (do_push)
			store[wr_ptr] <= push_data;
	end

endmodule

// File: hw/mem_target.sv
// Memory target
// Pops commands from the FIFO, runs them against a word memory and
// returns one response per command; the response is held until taken
// Memory is indexed by the low address bits, so addresses alias

module mem_target
	import memcmd_pkg::*;
#(
	parameter int MEM_WORDS = DEF_MEM_WORDS
)
(
	input  logic rvx_port_26,
	input  logic rvx_port_24,

	// FIFO side
	input  logic fifo_valid,
	input  cmd_t fifo_head,
	output logic fifo_pop,

	// Response path
	output logic rsp_valid,
	input  logic rsp_ready,
	output rsp_t rsp
);

	localparam int IDX_W = $clog2(MEM_WORDS);

	typedef logic [IDX_W-1:0] idx_t;

	// ********************************************************************
	// Command stage
	// ********************************************************************

	data_t mem [MEM_WORDS];

	// Command popped and waiting to execute
	cmd_t cur;
	logic cur_valid;
	idx_t idx;

	// Response taken by the bridge
	logic rsp_hs;

	assign rsp_hs = rsp_valid & rsp_ready;
	assign idx    = cur.addr[IDX_W-1:0];

	// Pop only with nothing in execution and no response pending
	assign fifo_pop = fifo_valid & ~cur_valid & ~rsp_valid;

	always_ff @(posedge rvx_port_26)
	begin
		if (fifo_pop)
			cur <= fifo_head;
	end

	// ********************************************************************
	// Execute and respond
	// ********************************************************************

	always_ff @(posedge rvx_port_26 or negedge rvx_port_24)
	begin
		if (!rvx_port_24)
		begin
			cur_valid <= 1'b0;
			rsp_valid <= 1'b0;
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= '0;
		end
		else
		begin
			// Load a new command
			if (fifo_pop)
				cur_valid <= 1'b1;
			// Execute one cycle after the pop
			if (cur_valid)
			begin
				cur_valid <= 1'b0;
				rsp_valid <= 1'b1;
				if (cur.write)
					mem[idx] <= cur.wdata;
			end
			else if (rsp_hs)
			begin
				rsp_valid <= 1'b0;
			end
		end
	end

	// Read data captured at execute, zero for writes
	always_ff @(posedge rvx_port_26)
	begin
		if (cur_valid)
			rsp.rdata <= cur.write ? '0 : mem[idx];
	end

endmodule

// File: hw/memcmd_top.sv
// Top level of the memory-command subsystem
// Connects the request bridge, the command FIFO and the memory target,
// and passes the FIFO depth and memory size down
// With an idle FIFO, req_done follows request acceptance by 4 cycles

module memcmd_top
	import memcmd_pkg::*;
#(
	parameter int FIFO_DEPTH = DEF_FIFO_DEPTH,
	parameter int MEM_WORDS  = DEF_MEM_WORDS
)
(
	input  logic  rvx_port_26,
	input  logic  rvx_port_24,
	input  logic  req_valid,
	input  logic  req_sel,
	input  logic  req_write,
	input  addr_t req_addr,
	input  data_t req_wdata,
	output logic  req_done,
	output data_t req_rdata
);

	// Bridge to FIFO
	logic cmd_valid;
	logic cmd_ready;
	cmd_t cmd;
	logic fifo_full;

	// FIFO to target
	logic fifo_valid;
	logic fifo_pop;
	cmd_t fifo_head;

	// Target to bridge
	logic rsp_valid;
	logic rsp_ready;
	rsp_t rsp;

	// FIFO accepts whenever it has room
	assign cmd_ready = ~fifo_full;

	req_cmd_bridge u_bridge (
		.rvx_port_26 (rvx_port_26),
		.rvx_port_24 (rvx_port_24),
		.req_valid   (req_valid),
		.req_sel     (req_sel),
		.req_write   (req_write),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.req_done    (req_done),
		.req_rdata   (req_rdata),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd         (cmd),
		.rsp_valid   (rsp_valid),
		.rsp_ready   (rsp_ready),
		.rsp         (rsp)
	);

	cmd_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.rvx_port_26 (rvx_port_26),
		.rvx_port_24 (rvx_port_24),
		.push        (cmd_valid),
		.push_data   (cmd),
		.pop         (fifo_pop),
		.full        (fifo_full),
		.valid       (fifo_valid),
		.head        (fifo_head)
	);

	mem_target #(
		.MEM_WORDS (MEM_WORDS)
	) u_target (
		.rvx_port_26 (rvx_port_26),
		.rvx_port_24 (rvx_port_24),
		.fifo_valid  (fifo_valid),
		.fifo_head   (fifo_head),
		.fifo_pop    (fifo_pop),
		.rsp_valid   (rsp_valid),
		.rsp_ready   (rsp_ready),
		.rsp         (rsp)
	);

endmodule

// File: dv/tb_clkgen.sv
// Clock and reset source for the testbench
// Free-running clock of PERIOD_NS and an active-low reset held for
// RESET_CYCLES rising edges, released on a falling edge

module tb_clkgen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 4
)
(
	output logic rvx_port_26,
	output logic rvx_port_24
);

	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		rvx_port_26 = 1'b0;
		forever
			#(PERIOD_NS / 2) rvx_port_26 = ~rvx_port_26;
	end

	// Release away from the rising edge
	initial
	begin
		rvx_port_24 = 1'b0;
		repeat (RESET_CYCLES) @(posedge rvx_port_26);
		@(negedge rvx_port_26);
		rvx_port_24 = 1'b1;
	end

endmodule

// File: dv/memcmd_props.sv
// Concurrent assertions on the bridge and FIFO handshakes
// Bound once into the bridge and once into the FIFO
// Each bind ties off the ports that the other side would drive

module memcmd_props
	import memcmd_pkg::*;
(
	input logic          rvx_port_26,
	input logic          rvx_port_24,
	input bridge_state_t state,
	input logic          req_done,
	input logic          cmd_valid,
	input logic          cmd_ready,
	input cmd_t          cmd,
	input logic          push,
	input logic          full
);

	timeunit 1ns;
	timeprecision 100ps;

	// Failed assertions seen so far
	int assert_fails = 0;

	// Command held steady under back-pressure
	cmd_stable_a: assert property (@(posedge rvx_port_26) disable iff (!rvx_port_24)
		(cmd_valid && !cmd_ready) |=> $stable(cmd))
	else
	begin
		$error("cmd changed while cmd_valid high and cmd_ready low");
		assert_fails++;
	end

	// Response taken only after the command left or together with it
	done_busy_a: assert property (@(posedge rvx_port_26) disable iff (!rvx_port_24)
		req_done |-> ((state == st_rsp) || (cmd_valid && cmd_ready)))
	else
	begin
		$error("req_done seen before the command was transferred");
		assert_fails++;
	end

	// One outstanding command never fills the FIFO
	push_full_a: assert property (@(posedge rvx_port_26) disable iff (!rvx_port_24)
		!(push && full))
	else
	begin
		$error("push while the FIFO is full");
		assert_fails++;
	end

endmodule

bind req_cmd_bridge memcmd_props u_bridge_props (
	.rvx_port_26 (rvx_port_26),
	.rvx_port_24 (rvx_port_24),
	.state       (state),
	.req_done    (req_done),
	.cmd_valid   (cmd_valid),
	.cmd_ready   (cmd_ready),
	.cmd         (cmd),
	.push        (1'b0),
	.full        (1'b0)
);

bind cmd_fifo memcmd_props u_fifo_props (
	.rvx_port_26 (rvx_port_26),
	.rvx_port_24 (rvx_port_24),
	.state       (memcmd_pkg::st_rsp),
	.req_done    (1'b0),
	.cmd_valid   (1'b0),
	.cmd_ready   (1'b1),
	.cmd         ('0),
	.push        (push),
	.full        (full)
);

// File: dv/memcmd_tb.sv
// Testbench top for the memory-command subsystem
// Loads requests and expected read data from the test data file, drives
// them on the falling clock edge and checks every response against the
// file and a reference memory model
// One result line per test and a closing line with the counts

module memcmd_tb
	import memcmd_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam string DATA_FILE   = "dv/memcmd_testdata.txt";
	localparam int    MAX_LINES   = 64;
	localparam int    MEM_WORDS   = DEF_MEM_WORDS;
	localparam int    DONE_LIMIT  = 50;
	localparam int    IDLE_WINDOW = 20;
	// Test run without idle gaps
	localparam int    B2B_TEST    = 5;

	logic  rvx_port_26;
	logic  rvx_port_24;
	logic  req_valid;
	logic  req_sel;
	logic  req_write;
	addr_t req_addr;
	data_t req_wdata;
	logic  req_done;
	data_t req_rdata;

	// Loaded test data with one entry per request
	int    line_test  [MAX_LINES];
	logic  [7:0] line_op [MAX_LINES];
	addr_t line_addr  [MAX_LINES];
	data_t line_wdata [MAX_LINES];
	data_t line_exp   [MAX_LINES];
	int    num_lines  = 0;
	logic  loaded     = 1'b0;

	data_t ref_mem [MEM_WORDS];
	int    seed;
	int    errors;
	int    checks;
	int    tests_run;
	int    tests_failed;
	int    done_count = 0;

	tb_clkgen #(
		.PERIOD_NS    (20),
		.RESET_CYCLES (4)
	) u_clkgen (
		.rvx_port_26 (rvx_port_26),
		.rvx_port_24 (rvx_port_24)
	);

	memcmd_top #(
		.FIFO_DEPTH (DEF_FIFO_DEPTH),
		.MEM_WORDS  (MEM_WORDS)
	) dut0 (
		.rvx_port_26 (rvx_port_26),
		.rvx_port_24 (rvx_port_24),
		.req_valid   (req_valid),
		.req_sel     (req_sel),
		.req_write   (req_write),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.req_done    (req_done),
		.req_rdata   (req_rdata)
	);

	// Every done strobe counted at the rising edge
	always @(posedge rvx_port_26)
	begin
		if (rvx_port_24 && req_done)
			done_count <= done_count + 1;
	end

	// ********************************************************************
	// Helpers
	// ********************************************************************

	task automatic check_value(input string what, input data_t got, input data_t exp);
		checks++;
		if (got !== exp)
		begin
			$display("Error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic load_test_data();
		int          fd;
		int          n;
		int          test_id;
		string       line;
		logic [7:0]  op_c;
		logic [31:0] a;
		logic [31:0] w;
		logic [31:0] e;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0)
		begin
			$display("Could not open test data file %s", DATA_FILE);
			errors++;
			return;
		end
		while (!$feof(fd) && num_lines < MAX_LINES)
		begin
			line = "";
			n = $fgets(line, fd);
			// Skip blank and comment lines
			if (n > 1 && line.getc(0) != "#")
			begin
				if ($sscanf(line, "%d %c %h %h %h", test_id, op_c, a, w, e) == 5)
				begin
					line_test[num_lines]  = test_id;
					line_op[num_lines]    = op_c;
					line_addr[num_lines]  = a[15:0];
					line_wdata[num_lines] = w;
					line_exp[num_lines]   = e;
					num_lines++;
				end
				else
				begin
					$display("Malformed test data line: %s", line);
					errors++;
				end
			end
		end
		$fclose(fd);
	endtask

	// Host request levels back to idle
	task automatic release_request();
		req_valid = 1'b0;
		req_sel   = 1'b0;
		req_write = 1'b0;
	endtask

	// Hold one request until req_done or until limit cycles have passed
	task automatic drive_request(input int idx, input logic sel, input int limit,
		output data_t rdata, output logic got_done);
		int cycles;
		cycles    = 0;
		got_done  = 1'b0;
		rdata     = '0;
		req_valid = 1'b1;
		req_sel   = sel;
		req_write = (line_op[idx] == "W");
		req_addr  = line_addr[idx];
		req_wdata = line_wdata[idx];
		while (!got_done && cycles < limit)
		begin
			@(negedge rvx_port_26);
			cycles++;
			if (req_done)
			begin
				got_done = 1'b1;
				rdata    = req_rdata;
			end
		end
	endtask

	// ********************************************************************
	// Test sequencing
	// ********************************************************************

	task automatic run_line(input int idx, inout int reqs);
		data_t rdata;
		data_t model;
		logic  got_done;
		int    gap;
		int    slot;
		// Reference memory aliases modulo its size
		slot = int'(line_addr[idx]) % MEM_WORDS;
		if (line_op[idx] == "N")
		begin
			drive_request(idx, 1'b0, IDLE_WINDOW, rdata, got_done);
			check_value("done strobe on unselected request", data_t'(got_done), '0);
		end
		else
		begin
			drive_request(idx, 1'b1, DONE_LIMIT, rdata, got_done);
			reqs++;
			if (!got_done)
			begin
				$display("Request %0d got no done strobe within %0d cycles", idx, DONE_LIMIT);
				errors++;
			end
			else
			begin
				if (line_op[idx] == "W")
				begin
					model = '0;
					ref_mem[slot] = line_wdata[idx];
				end
				else
				begin
					model = ref_mem[slot];
				end
				check_value("read data against data file", rdata, line_exp[idx]);
				check_value("read data against memory model", rdata, model);
			end
		end
		// Idle gap before the next request
		if (line_test[idx] == B2B_TEST)
			gap = 0;
		else
			gap = int'($unsigned($random(seed)) % 4);
		if (gap > 0)
		begin
			release_request();
			repeat (gap) @(negedge rvx_port_26);
		end
	endtask

	task automatic finish_test(input int test_id, input int err_start,
		input int done_start, input int reqs);
		release_request();
		// Lets the last done strobe reach the counter
		@(negedge rvx_port_26);
		check_value("done strobe count", data_t'(done_count - done_start), data_t'(reqs));
		tests_run++;
		if (errors == err_start)
		begin
			$display("Test %0d ok, %0d requests", test_id, reqs);
		end
		else
		begin
			tests_failed++;
			$display("Test %0d failed with %0d errors", test_id, errors - err_start);
		end
	endtask

	task automatic run_all();
		int cur_test;
		int err_start;
		int done_start;
		int reqs;
		cur_test   = -1;
		err_start  = 0;
		done_start = 0;
		reqs       = 0;
		for (int i = 0; i < num_lines; i++)
		begin
			// New test id closes the previous test
			if (line_test[i] != cur_test)
			begin
				if (cur_test >= 0)
					finish_test(cur_test, err_start, done_start, reqs);
				cur_test   = line_test[i];
				err_start  = errors;
				done_start = done_count;
				reqs       = 0;
			end
			run_line(i, reqs);
		end
		if (cur_test >= 0)
			finish_test(cur_test, err_start, done_start, reqs);
	endtask

	// ********************************************************************
	// Main flow and watchdog
	// ********************************************************************

	initial
	begin
		req_valid    = 1'b0;
		req_sel      = 1'b0;
		req_write    = 1'b0;
		req_addr     = '0;
		req_wdata    = '0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		seed         = 46;
		for (int i = 0; i < MEM_WORDS; i++)
			ref_mem[i] = '0;
		load_test_data();
		loaded = 1'b1;
		wait (rvx_port_24 === 1'b1);
		@(negedge rvx_port_26);
		run_all();
		// Failed handshake assertions in the bound checkers
		errors += dut0.u_bridge.u_bridge_props.assert_fails;
		errors += dut0.u_fifo.u_fifo_props.assert_fails;
		$display("Tests %0d run, %0d failed; checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Budget of 50 cycles per request plus setup time
	initial
	begin
		int limit;
		wait (loaded === 1'b1);
		limit = num_lines * 50 + 200;
		repeat (limit) @(posedge rvx_port_26);
		$display("Watchdog expired after %0d cycles, the run did not finish", limit);
		$display("Regression failed");
		$finish;
	end

endmodule

// File: dv/memcmd_testdata.txt
# One request per line, all numbers after the op in hex
# Columns: test id, op (R read, W write, N not selected), addr, wdata, expected rdata
1 R 0000 00000000 00000000
1 R 0001 00000000 00000000
1 R 007f 00000000 00000000
1 R 00ff 00000000 00000000
1 R 1234 00000000 00000000
2 W 0010 deadbeef 00000000
2 R 0010 00000000 deadbeef
2 W 0010 cafef00d 00000000
2 R 0010 00000000 cafef00d
2 W 0042 01234567 00000000
2 R 0042 00000000 01234567
3 W 0120 a5a5a5a5 00000000
3 R 0020 00000000 a5a5a5a5
3 W 0305 5a5a0f0f 00000000
3 R 0005 00000000 5a5a0f0f
3 R 0205 00000000 5a5a0f0f
4 W 0030 11112222 00000000
4 N 0030 99999999 00000000
4 R 0030 00000000 11112222
4 N 0031 77777777 00000000
4 R 0031 00000000 00000000
5 W 0050 00c0ffee 00000000
5 R 0050 00000000 00c0ffee
5 W 0051 13579bdf 00000000
5 W 0152 2468ace0 00000000
5 R 0052 00000000 2468ace0
5 R 0051 00000000 13579bdf
5 W 0050 0badf00d 00000000
5 R 0050 00000000 0badf00d

// File: verilog.f
hw/memcmd_pkg.sv
hw/req_cmd_bridge.sv
hw/cmd_fifo.sv
hw/mem_target.sv
hw/memcmd_top.sv
dv/tb_clkgen.sv
dv/memcmd_props.sv
dv/memcmd_tb.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
TOP        ?= memcmd_tb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Result comes from the log, not from the exit code of the run
sim: build
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
